// ==== source/regfile_pkg.sv ====
`default_nettype none

package regfile_pkg;

  localparam int DATA_WIDTH = 64;
  localparam int PHYS_ADDR_WIDTH = 6;
  localparam int ARCH_ADDR_WIDTH = 5;

  localparam int NUM_WRITE = 3;
  localparam int NUM_READ = 2;

  localparam int PHYS_REGS = 1 << PHYS_ADDR_WIDTH;  // renamed registers behind the rename stage
  localparam int ARCH_REGS = 1 << ARCH_ADDR_WIDTH;  // retired architectural state

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [PHYS_ADDR_WIDTH-1:0] phys_addr_t;
  typedef logic [ARCH_ADDR_WIDTH-1:0] arch_addr_t;

endpackage

`default_nettype wire

// ==== source/write_stage_pipe.sv ====
`default_nettype none

module write_stage_pipe (
  input  logic                                                clk,
  input  logic                                                rst,
  input  regfile_pkg::phys_addr_t [regfile_pkg::NUM_WRITE-1:0] write_addr,
  input  regfile_pkg::data_t      [regfile_pkg::NUM_WRITE-1:0] write_data,
  input  logic                    [regfile_pkg::NUM_WRITE-1:0] write_wen,
  output regfile_pkg::phys_addr_t [regfile_pkg::NUM_WRITE-1:0] s1_addr,
  output regfile_pkg::phys_addr_t [regfile_pkg::NUM_WRITE-1:0] s2_addr,
  output regfile_pkg::data_t      [regfile_pkg::NUM_WRITE-1:0] s1_data,
  output regfile_pkg::data_t      [regfile_pkg::NUM_WRITE-1:0] s2_data,
  output logic                    [regfile_pkg::NUM_WRITE-1:0] s1_wen,
  output logic                    [regfile_pkg::NUM_WRITE-1:0] s2_wen
);
  import regfile_pkg::*;

  // the enables always shift, so a bubble clears the stage behind it
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_wen <= '0;
      s2_wen <= '0;
    end else begin
      s1_wen <= write_wen;
      s2_wen <= s1_wen;
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_WRITE; p++) begin
      if (write_wen[p]) begin
        s1_addr[p] <= write_addr[p];
        s1_data[p] <= write_data[p];  // payload moves only with a live write
      end
      if (s1_wen[p]) begin
        s2_addr[p] <= s1_addr[p];
        s2_data[p] <= s1_data[p];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/phys_reg_ram.sv ====
`default_nettype none

module phys_reg_ram (
  input  logic                                                clk,
  input  regfile_pkg::phys_addr_t [regfile_pkg::NUM_WRITE-1:0] wr_addr,
  input  regfile_pkg::data_t      [regfile_pkg::NUM_WRITE-1:0] wr_data,
  input  logic                    [regfile_pkg::NUM_WRITE-1:0] wr_en,
  input  regfile_pkg::phys_addr_t [regfile_pkg::NUM_READ:0]    rd_addr,
  output regfile_pkg::data_t      [regfile_pkg::NUM_READ:0]    rd_data
);
  import regfile_pkg::*;

  data_t mem [PHYS_REGS];

  // later ports overwrite earlier ones, so port NUM_WRITE-1 wins a clash
  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_WRITE; p++) begin
      if (wr_en[p]) begin
        mem[wr_addr[p]] <= wr_data[p];
      end
    end
  end

  // the last read port is the retire lookup
  always_comb begin
    for (int r = 0; r <= NUM_READ; r++) begin
      rd_data[r] = mem[rd_addr[r]];
    end
  end

endmodule

`default_nettype wire

// ==== source/bypass_select.sv ====
`default_nettype none

module bypass_select (
  input  regfile_pkg::phys_addr_t                              addr,
  input  regfile_pkg::data_t                                   ram_data,
  input  regfile_pkg::phys_addr_t [regfile_pkg::NUM_WRITE-1:0] in_addr,
  input  regfile_pkg::phys_addr_t [regfile_pkg::NUM_WRITE-1:0] s1_addr,
  input  regfile_pkg::phys_addr_t [regfile_pkg::NUM_WRITE-1:0] s2_addr,
  input  regfile_pkg::data_t      [regfile_pkg::NUM_WRITE-1:0] in_data,
  input  regfile_pkg::data_t      [regfile_pkg::NUM_WRITE-1:0] s1_data,
  input  regfile_pkg::data_t      [regfile_pkg::NUM_WRITE-1:0] s2_data,
  input  logic                    [regfile_pkg::NUM_WRITE-1:0] in_wen,
  input  logic                    [regfile_pkg::NUM_WRITE-1:0] s1_wen,
  input  logic                    [regfile_pkg::NUM_WRITE-1:0] s2_wen,
  output regfile_pkg::data_t                                   fwd_data
);
  import regfile_pkg::*;

  // Oldest source first. Each later match overrides the earlier one, which
  // gives the incoming write top priority and the highest port the last word
  // inside a level.
  always_comb begin
    fwd_data = ram_data;
    for (int p = 0; p < NUM_WRITE; p++) begin
      if (s2_wen[p] && (s2_addr[p] == addr)) begin
        fwd_data = s2_data[p];  // about to land in storage at the next edge
      end
    end
    for (int p = 0; p < NUM_WRITE; p++) begin
      if (s1_wen[p] && (s1_addr[p] == addr)) begin
        fwd_data = s1_data[p];
      end
    end
    for (int p = 0; p < NUM_WRITE; p++) begin
      if (in_wen[p] && (in_addr[p] == addr)) begin
        fwd_data = in_data[p];  // write presented in the same cycle as the read
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/read_port.sv ====
`default_nettype none

module read_port (
  input  logic                                                clk,
  input  logic                                                rst,
  input  logic                                                read_en,
  input  logic                                                oe,
  input  logic                                                const_en,
  input  regfile_pkg::phys_addr_t                              addr,
  input  regfile_pkg::data_t                                   const_val,
  input  regfile_pkg::data_t                                   ram_data,
  input  regfile_pkg::data_t                                   rrf_data,
  input  regfile_pkg::phys_addr_t [regfile_pkg::NUM_WRITE-1:0] in_addr,
  input  regfile_pkg::phys_addr_t [regfile_pkg::NUM_WRITE-1:0] s1_addr,
  input  regfile_pkg::phys_addr_t [regfile_pkg::NUM_WRITE-1:0] s2_addr,
  input  regfile_pkg::data_t      [regfile_pkg::NUM_WRITE-1:0] in_data,
  input  regfile_pkg::data_t      [regfile_pkg::NUM_WRITE-1:0] s1_data,
  input  regfile_pkg::data_t      [regfile_pkg::NUM_WRITE-1:0] s2_data,
  input  logic                    [regfile_pkg::NUM_WRITE-1:0] in_wen,
  input  logic                    [regfile_pkg::NUM_WRITE-1:0] s1_wen,
  input  logic                    [regfile_pkg::NUM_WRITE-1:0] s2_wen,
  output regfile_pkg::data_t                                   read_data
);
  import regfile_pkg::*;

  data_t fwd_data;

  bypass_select u_bypass (
    .addr     (addr),
    .ram_data (ram_data),
    .in_addr  (in_addr),
    .s1_addr  (s1_addr),
    .s2_addr  (s2_addr),
    .in_data  (in_data),
    .s1_data  (s1_data),
    .s2_data  (s2_data),
    .in_wen   (in_wen),
    .s1_wen   (s1_wen),
    .s2_wen   (s2_wen),
    .fwd_data (fwd_data)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      read_data <= '0;
    end else if (read_en) begin
      if (const_en) begin
        read_data <= const_val;  // immediate operand overrides the register
      end else if (oe) begin
        read_data <= fwd_data;
      end else begin
        read_data <= rrf_data;  // value already retired to the architectural file
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/arch_reg_file.sv ====
`default_nettype none

module arch_reg_file (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic                                               wr_en,
  input  regfile_pkg::arch_addr_t                             wr_addr,
  input  regfile_pkg::data_t                                  wr_data,
  input  regfile_pkg::arch_addr_t [regfile_pkg::NUM_READ-1:0] rd_addr,
  output regfile_pkg::data_t      [regfile_pkg::NUM_READ-1:0] rd_data
);
  import regfile_pkg::*;

  data_t mem [ARCH_REGS];

  // architectural state starts as all zeros
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_comb begin
    for (int r = 0; r < NUM_READ; r++) begin
      rd_data[r] = mem[rd_addr[r]];
    end
  end

endmodule

`default_nettype wire

// ==== source/regfile_top.sv ====
`default_nettype none

module regfile_top (
  input  logic                                                clk,
  input  logic                                                rst,
  input  regfile_pkg::phys_addr_t [regfile_pkg::NUM_WRITE-1:0] write_addr,
  input  regfile_pkg::data_t      [regfile_pkg::NUM_WRITE-1:0] write_data,
  input  logic                    [regfile_pkg::NUM_WRITE-1:0] write_wen,
  input  logic                    [regfile_pkg::NUM_READ-1:0]  read_en,
  input  regfile_pkg::phys_addr_t [regfile_pkg::NUM_READ-1:0]  read_addr,
  input  regfile_pkg::arch_addr_t [regfile_pkg::NUM_READ-1:0]  read_rrf_addr,
  input  logic                    [regfile_pkg::NUM_READ-1:0]  read_oe,
  input  logic                    [regfile_pkg::NUM_READ-1:0]  read_const_en,
  input  regfile_pkg::data_t      [regfile_pkg::NUM_READ-1:0]  read_const,
  output regfile_pkg::data_t      [regfile_pkg::NUM_READ-1:0]  read_data,
  input  logic                                                retire_en,
  input  regfile_pkg::phys_addr_t                              retire_addr,
  input  regfile_pkg::arch_addr_t                              retire_rrf_addr
);
  import regfile_pkg::*;

  phys_addr_t [NUM_WRITE-1:0] s1_addr;
  phys_addr_t [NUM_WRITE-1:0] s2_addr;
  data_t      [NUM_WRITE-1:0] s1_data;
  data_t      [NUM_WRITE-1:0] s2_data;
  logic       [NUM_WRITE-1:0] s1_wen;
  logic       [NUM_WRITE-1:0] s2_wen;

  data_t [NUM_READ:0]   ram_rd_data;  // top entry feeds the retire path
  data_t [NUM_READ-1:0] rrf_rd_data;
  data_t                retire_data;

  write_stage_pipe u_pipe (
    .clk        (clk),
    .rst        (rst),
    .write_addr (write_addr),
    .write_data (write_data),
    .write_wen  (write_wen),
    .s1_addr    (s1_addr),
    .s2_addr    (s2_addr),
    .s1_data    (s1_data),
    .s2_data    (s2_data),
    .s1_wen     (s1_wen),
    .s2_wen     (s2_wen)
  );

  phys_reg_ram u_ram (
    .clk     (clk),
    .wr_addr (s2_addr),
    .wr_data (s2_data),
    .wr_en   (s2_wen),
    .rd_addr ({retire_addr, read_addr}),
    .rd_data (ram_rd_data)
  );

  // retire sees in-flight writes too, so a same-cycle write retires correctly
  bypass_select u_retire_bypass (
    .addr     (retire_addr),
    .ram_data (ram_rd_data[NUM_READ]),
    .in_addr  (write_addr),
    .s1_addr  (s1_addr),
    .s2_addr  (s2_addr),
    .in_data  (write_data),
    .s1_data  (s1_data),
    .s2_data  (s2_data),
    .in_wen   (write_wen),
    .s1_wen   (s1_wen),
    .s2_wen   (s2_wen),
    .fwd_data (retire_data)
  );

  arch_reg_file u_rrf (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (retire_en),
    .wr_addr (retire_rrf_addr),
    .wr_data (retire_data),
    .rd_addr (read_rrf_addr),
    .rd_data (rrf_rd_data)
  );

  for (genvar r = 0; r < NUM_READ; r++) begin : g_read
    read_port u_port (
      .clk       (clk),
      .rst       (rst),
      .read_en   (read_en[r]),
      .oe        (read_oe[r]),
      .const_en  (read_const_en[r]),
      .addr      (read_addr[r]),
      .const_val (read_const[r]),
      .ram_data  (ram_rd_data[r]),
      .rrf_data  (rrf_rd_data[r]),
      .in_addr   (write_addr),
      .s1_addr   (s1_addr),
      .s2_addr   (s2_addr),
      .in_data   (write_data),
      .s1_data   (s1_data),
      .s2_data   (s2_data),
      .in_wen    (write_wen),
      .s1_wen    (s1_wen),
      .s2_wen    (s2_wen),
      .read_data (read_data[r])
    );
  end

endmodule

`default_nettype wire

// ==== tb/regfile_asserts.sv ====
`default_nettype none

module regfile_asserts (
  input logic                              clk,
  input logic                              rst,
  input logic [regfile_pkg::NUM_WRITE-1:0] write_wen,
  input logic [regfile_pkg::NUM_WRITE-1:0] s1_wen,
  input logic [regfile_pkg::NUM_WRITE-1:0] s2_wen
);
  timeunit 1ns;
  timeprecision 100ps;

  int failures = 0;

  // stage two always takes what stage one held one cycle earlier
  stage_shift: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> (s2_wen == $past(s1_wen)))
    else begin
      $error("stage two write enable did not follow stage one");
      failures++;
    end

  reset_clears: assert property (@(posedge clk)
    $past(rst) |-> (s1_wen == '0 && s2_wen == '0))
    else begin
      $error("stage write enables not cleared after reset");
      failures++;
    end

  wen_known: assert property (@(posedge clk) !rst |-> !$isunknown(write_wen))
    else begin
      $error("write enable input is unknown");
      failures++;
    end

endmodule

bind write_stage_pipe regfile_asserts u_checks (
  .clk       (clk),
  .rst       (rst),
  .write_wen (write_wen),
  .s1_wen    (s1_wen),
  .s2_wen    (s2_wen)
);

`default_nettype wire

// ==== tb/regfile_tb.sv ====
`default_nettype none

module regfile_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import regfile_pkg::*;

  localparam logic [31:0] LFSR_SEED = 32'hde7b;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam int MAX_CYCLES = 600;  // about twice the summed test lengths

  logic clk;
  logic rst;
  phys_addr_t [NUM_WRITE-1:0] write_addr;
  data_t      [NUM_WRITE-1:0] write_data;
  logic       [NUM_WRITE-1:0] write_wen;
  logic       [NUM_READ-1:0]  read_en;
  phys_addr_t [NUM_READ-1:0]  read_addr;
  arch_addr_t [NUM_READ-1:0]  read_rrf_addr;
  logic       [NUM_READ-1:0]  read_oe;
  logic       [NUM_READ-1:0]  read_const_en;
  data_t      [NUM_READ-1:0]  read_const;
  data_t      [NUM_READ-1:0]  read_data;
  logic                       retire_en;
  phys_addr_t                 retire_addr;
  arch_addr_t                 retire_rrf_addr;

  // values for the next drive edge, built up by the put_* tasks
  phys_addr_t [NUM_WRITE-1:0] nxt_waddr;
  data_t      [NUM_WRITE-1:0] nxt_wdata;
  logic       [NUM_WRITE-1:0] nxt_wen;
  logic       [NUM_READ-1:0]  nxt_ren;
  phys_addr_t [NUM_READ-1:0]  nxt_raddr;
  arch_addr_t [NUM_READ-1:0]  nxt_rrf;
  logic       [NUM_READ-1:0]  nxt_oe;
  logic       [NUM_READ-1:0]  nxt_cen;
  data_t      [NUM_READ-1:0]  nxt_cval;
  logic                       nxt_ret_en;
  phys_addr_t                 nxt_ret_addr;
  arch_addr_t                 nxt_ret_rrf;

  data_t phys_model [PHYS_REGS];
  data_t arch_model [ARCH_REGS];
  data_t exp_data [NUM_READ];  // what read_data must show after the next sampling edge

  logic [31:0] lfsr_state;
  int errors;
  int assert_fails;
  int cycle_count = 0;
  string test_name;

  regfile_top DUT (
    .clk             (clk),
    .rst             (rst),
    .write_addr      (write_addr),
    .write_data      (write_data),
    .write_wen       (write_wen),
    .read_en         (read_en),
    .read_addr       (read_addr),
    .read_rrf_addr   (read_rrf_addr),
    .read_oe         (read_oe),
    .read_const_en   (read_const_en),
    .read_const      (read_const),
    .read_data       (read_data),
    .retire_en       (retire_en),
    .retire_addr     (retire_addr),
    .retire_rrf_addr (retire_rrf_addr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] bits;
    logic lsb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
        lfsr_state = lfsr_state ^ LFSR_TAPS;
      end
      bits = {bits[62:0], lsb};
    end
    return bits;
  endfunction

  task automatic compare(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s: expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic clear_next();
    nxt_waddr = '0;
    nxt_wdata = '0;
    nxt_wen = '0;
    nxt_ren = '0;
    nxt_raddr = '0;
    nxt_rrf = '0;
    nxt_oe = '0;
    nxt_cen = '0;
    nxt_cval = '0;
    nxt_ret_en = 1'b0;
    nxt_ret_addr = '0;
    nxt_ret_rrf = '0;
  endtask

  task automatic put_write(input int port, input phys_addr_t addr, input data_t data);
    nxt_wen[port] = 1'b1;
    nxt_waddr[port] = addr;
    nxt_wdata[port] = data;
  endtask

  task automatic put_read(input int port, input phys_addr_t addr, input logic oe,
                          input logic cen, input data_t cval, input arch_addr_t rrf);
    nxt_ren[port] = 1'b1;
    nxt_raddr[port] = addr;
    nxt_oe[port] = oe;
    nxt_cen[port] = cen;
    nxt_cval[port] = cval;
    nxt_rrf[port] = rrf;
  endtask

  task automatic put_retire(input phys_addr_t addr, input arch_addr_t rrf);
    nxt_ret_en = 1'b1;
    nxt_ret_addr = addr;
    nxt_ret_rrf = rrf;
  endtask

  task automatic drive_inputs();
    write_addr <= nxt_waddr;
    write_data <= nxt_wdata;
    write_wen <= nxt_wen;
    read_en <= nxt_ren;
    read_addr <= nxt_raddr;
    read_rrf_addr <= nxt_rrf;
    read_oe <= nxt_oe;
    read_const_en <= nxt_cen;
    read_const <= nxt_cval;
    retire_en <= nxt_ret_en;
    retire_addr <= nxt_ret_addr;
    retire_rrf_addr <= nxt_ret_rrf;
  endtask

  // Writes land first, higher port last, so a read in the same cycle sees them.
  // The architectural file only changes after this cycle's reads are taken.
  function automatic void update_model();
    for (int p = 0; p < NUM_WRITE; p++) begin
      if (nxt_wen[p]) begin
        phys_model[nxt_waddr[p]] = nxt_wdata[p];
      end
    end
    for (int r = 0; r < NUM_READ; r++) begin
      if (nxt_ren[r]) begin
        if (nxt_cen[r]) begin
          exp_data[r] = nxt_cval[r];
        end else if (nxt_oe[r]) begin
          exp_data[r] = phys_model[nxt_raddr[r]];
        end else begin
          exp_data[r] = arch_model[nxt_rrf[r]];
        end
      end
    end
    if (nxt_ret_en) begin
      arch_model[nxt_ret_rrf] = phys_model[nxt_ret_addr];
    end
  endfunction

  // drives one cycle and checks at mid-cycle the reads sampled at this edge
  task automatic tick();
    data_t prev_exp [NUM_READ];
    for (int r = 0; r < NUM_READ; r++) begin
      prev_exp[r] = exp_data[r];
    end
    @(posedge clk);
    drive_inputs();
    update_model();
    @(negedge clk);
    for (int r = 0; r < NUM_READ; r++) begin
      compare($sformatf("%s port %0d", test_name, r), prev_exp[r], read_data[r]);
    end
    clear_next();
  endtask

  task automatic idle(input int n);
    repeat (n) tick();
  endtask

  task automatic test_settled();
    test_name = "settled";
    for (int c = 0; c < 2; c++) begin
      for (int p = 0; p < NUM_WRITE; p++) begin
        put_write(p, phys_addr_t'((c * 3 + p) * 5 + 1),
                  64'ha000_0000_0000_0000 + (c * 3 + p) * 64'h0101);
      end
      tick();
    end
    idle(4);
    for (int c = 0; c < 3; c++) begin
      for (int r = 0; r < NUM_READ; r++) begin
        put_read(r, phys_addr_t'((c * 2 + r) * 5 + 1), 1'b1, 1'b0, '0, '0);
      end
      tick();
    end
    idle(1);
  endtask

  task automatic test_forward();
    test_name = "forward";
    for (int d = 0; d < 4; d++) begin
      put_write(d % NUM_WRITE, 6'd40, data_t'(take_bits(64)));
      if (d == 0) begin
        put_read(0, 6'd40, 1'b1, 1'b0, '0, '0);  // same cycle as the write
      end
      tick();
      if (d > 0) begin
        idle(d - 1);
        put_read(d % NUM_READ, 6'd40, 1'b1, 1'b0, '0, '0);
        tick();
      end
    end
    idle(1);
  endtask

  task automatic test_priority();
    data_t top_data;
    test_name = "priority";
    top_data = 64'h2222_3333_4444_5555;
    put_write(0, 6'd50, 64'h0000_0000_0000_0a0a);
    put_write(1, 6'd50, 64'h1111_0000_0000_1b1b);
    put_write(2, 6'd50, top_data);
    put_read(0, 6'd50, 1'b1, 1'b0, '0, '0);
    tick();
    idle(3);
    put_read(1, 6'd50, 1'b1, 1'b0, '0, '0);
    tick();
    idle(1);
    compare("priority same cycle", top_data, read_data[0]);
    compare("priority settled", top_data, read_data[1]);
  endtask

  task automatic test_const_hold();
    data_t const_val;
    test_name = "const_hold";
    const_val = 64'hc0de_7a07_0000_00ff;
    put_write(0, 6'd12, 64'h1234_5678_9abc_def0);
    tick();
    put_read(0, 6'd12, 1'b1, 1'b1, const_val, '0);
    put_read(1, 6'd12, 1'b1, 1'b0, '0, '0);
    tick();
    for (int i = 0; i < 4; i++) begin
      put_write(1, 6'd12, data_t'(take_bits(64)));  // register changes while reads idle
      nxt_raddr[0] = phys_addr_t'(take_bits(6));
      nxt_cval[0] = data_t'(take_bits(64));
      tick();
    end
    idle(1);
    compare("const_hold held constant", const_val, read_data[0]);
  endtask

  task automatic test_retire();
    data_t value;
    test_name = "retire";
    value = 64'hfeed_0000_beef_0001;
    put_read(0, '0, 1'b0, 1'b0, '0, 5'd7);
    tick();
    idle(1);
    compare("retire before any retire", '0, read_data[0]);
    put_write(2, 6'd33, value);
    put_retire(6'd33, 5'd9);
    tick();
    put_read(1, '0, 1'b0, 1'b0, '0, 5'd9);
    tick();
    idle(1);
    compare("retire same cycle write", value, read_data[1]);
  endtask

  task automatic test_random();
    phys_addr_t addr;
    arch_addr_t rrf;
    logic oe;
    logic cen;
    data_t value;
    test_name = "random";
    for (int i = 0; i < PHYS_REGS; i += NUM_WRITE) begin
      for (int p = 0; p < NUM_WRITE; p++) begin
        if (i + p < PHYS_REGS) begin
          put_write(p, phys_addr_t'(i + p), data_t'(take_bits(64)));  // no unknown words
        end
      end
      tick();
    end
    repeat (200) begin
      for (int p = 0; p < NUM_WRITE; p++) begin
        if (take_bits(1) == 1) begin
          addr = phys_addr_t'(take_bits(6));
          value = data_t'(take_bits(64));
          put_write(p, addr, value);
        end
      end
      for (int r = 0; r < NUM_READ; r++) begin
        if (take_bits(1) == 1) begin
          addr = phys_addr_t'(take_bits(6));
          rrf = arch_addr_t'(take_bits(5));
          oe = take_bits(1) == 1;
          cen = take_bits(2) == 3;
          value = data_t'(take_bits(64));
          put_read(r, addr, oe, cen, value, rrf);
        end
      end
      if (take_bits(1) == 1) begin
        addr = phys_addr_t'(take_bits(6));
        rrf = arch_addr_t'(take_bits(5));
        put_retire(addr, rrf);
      end
      tick();
    end
    idle(1);
  endtask

  initial begin
    errors = 0;
    lfsr_state = LFSR_SEED;
    test_name = "reset";
    clear_next();
    for (int i = 0; i < ARCH_REGS; i++) begin
      arch_model[i] = '0;
    end
    for (int r = 0; r < NUM_READ; r++) begin
      exp_data[r] = '0;
    end
    rst <= 1'b1;
    drive_inputs();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    test_settled();
    test_forward();
    test_priority();
    test_const_hold();
    test_retire();
    test_random();
    assert_fails = DUT.u_pipe.u_checks.failures;
    $display("check errors: %0d, assertion failures: %0d", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/regfile_pkg.sv
source/write_stage_pipe.sv
source/phys_reg_ram.sv
source/bypass_select.sv
source/read_port.sv
source/arch_reg_file.sv
source/regfile_top.sv
tb/regfile_asserts.sv
tb/regfile_tb.sv
